// File: src.f
+incdir+include
src/icache_pkg.sv
src/icache_tag_array.sv
src/icache_data_array.sv
src/icache_lru.sv
src/icache_pipe.sv
src/icache_top.sv
verification/icache_chk.sv
verification/icache_tb.sv

// File: verification/icache_tb.sv
// Instruction cache testbench
// Directed tests against a reference model of tags, blocks and
// pseudo-LRU bits: misses, fills, striping, replacement, poison

`timescale 1ns/1ps

`include "icache_macros.svh"

module icache_tb
  import icache_pkg::*;
;

  localparam int TIMEOUT = 100;
  localparam int IDX_LSB = `BYTE_OFFSET_WIDTH + `WORD_OFFSET_WIDTH;

  logic                          clk_i;
  logic                          reset_i;
  logic [`VADDR_WIDTH-1:0]       vaddr_i;
  logic                          vaddr_v_i;
  logic                          vaddr_ready_o;
  logic [`PTAG_WIDTH-1:0]        ptag_i;
  logic                          ptag_v_i;
  logic                          poison_i;
  logic [`INSTR_WIDTH-1:0]       data_o;
  logic                          data_v_o;
  logic                          miss_o;
  logic                          cache_req_v_o;
  logic [`PADDR_WIDTH-1:0]       cache_req_addr_o;
  logic                          cache_req_ready_i;
  logic                          cache_req_metadata_v_o;
  way_id_t                       cache_req_repl_way_o;
  logic                          cache_req_complete_i;
  logic                          tag_mem_pkt_v_i;
  tag_op_e                       tag_mem_pkt_op_i;
  index_t                        tag_mem_pkt_index_i;
  way_id_t                       tag_mem_pkt_way_i;
  tag_t                          tag_mem_pkt_tag_i;
  coh_state_e                    tag_mem_pkt_state_i;
  logic                          tag_mem_pkt_ready_o;
  logic                          data_mem_pkt_v_i;
  index_t                        data_mem_pkt_index_i;
  way_id_t                       data_mem_pkt_way_i;
  cache_block_t                  data_mem_pkt_data_i;
  logic                          data_mem_pkt_ready_o;
  logic                          stat_mem_pkt_v_i;
  index_t                        stat_mem_pkt_index_i;
  logic                          stat_mem_pkt_ready_o;

  // reference model
  tag_t         m_tag   [`ICACHE_SETS][`ICACHE_ASSOC];
  logic         m_valid [`ICACHE_SETS][`ICACHE_ASSOC];
  cache_block_t m_block [`ICACHE_SETS][`ICACHE_ASSOC];
  lru_t         m_lru   [`ICACHE_SETS];

  int errors;
  int checks;
  int tests_run;

  icache_top uut (.*);

  always #5 clk_i = ~clk_i;

  task automatic check_instr(input string name, input logic [`INSTR_WIDTH-1:0] got,
                             input logic [`INSTR_WIDTH-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_way(input string name, input way_id_t got, input way_id_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input logic [`PADDR_WIDTH-1:0] got,
                            input logic [`PADDR_WIDTH-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  function automatic logic ready_of(input int which);
    case (which)
      0:       return vaddr_ready_o;
      1:       return tag_mem_pkt_ready_o;
      2:       return data_mem_pkt_ready_o;
      default: return stat_mem_pkt_ready_o;
    endcase
  endfunction

  task automatic wait_ready(input int which, input string name);
    int n;
    n = 0;
    while (ready_of(which) !== 1'b1 && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if (ready_of(which) !== 1'b1) begin
      $display("Timeout at %0t: %s never went high", $time, name);
      $display("Simulation FAILED");
      $finish;
    end
  endtask

  function automatic logic [`PADDR_WIDTH-1:0] make_addr(input index_t set, input tag_t tag,
                                                        input logic [1:0] word,
                                                        input logic half);
    return {tag, set, word, half, 2'b00};
  endfunction

  function automatic cache_block_t random_block();
    cache_block_t b;
    for (int i = 0; i < `ICACHE_ASSOC; i++) begin
      b[i] = {$urandom, $urandom};
    end
    return b;
  endfunction

  // random tag not resident in the set
  function automatic tag_t fresh_tag(input index_t set);
    tag_t t;
    logic clash;
    t = '0;
    clash = 1'b1;
    while (clash) begin
      t = tag_t'($urandom);
      clash = 1'b0;
      for (int w = 0; w < `ICACHE_ASSOC; w++) begin
        if (m_valid[set][w] && m_tag[set][w] == t) clash = 1'b1;
      end
    end
    return t;
  endfunction

  function automatic int model_way(input logic [`PADDR_WIDTH-1:0] addr);
    index_t set;
    set = addr[IDX_LSB +: `INDEX_WIDTH];
    for (int w = 0; w < `ICACHE_ASSOC; w++) begin
      if (m_valid[set][w] && m_tag[set][w] == addr[`PADDR_WIDTH-1 -: `TAG_WIDTH]) return w;
    end
    return -1;
  endfunction

  // lowest invalid way, else walk the tree (0 is left)
  function automatic way_id_t model_victim(input index_t set);
    for (int w = 0; w < `ICACHE_ASSOC; w++) begin
      if (!m_valid[set][w]) return way_id_t'(w);
    end
    if (m_lru[set][0] == 1'b0) return {1'b0, m_lru[set][1]};
    return {1'b1, m_lru[set][2]};
  endfunction

  task automatic model_touch(input index_t set, input way_id_t way);
    if (way < 2) begin
      m_lru[set][0] = 1'b1;
      m_lru[set][1] = (way == 2'd0);
    end else begin
      m_lru[set][0] = 1'b0;
      m_lru[set][2] = (way == 2'd2);
    end
  endtask

  task automatic send_tag(input tag_op_e op, input index_t set, input way_id_t way,
                          input tag_t tag);
    wait_ready(1, "tag_mem_pkt_ready_o");
    tag_mem_pkt_v_i     = 1'b1;
    tag_mem_pkt_op_i    = op;
    tag_mem_pkt_index_i = set;
    tag_mem_pkt_way_i   = way;
    tag_mem_pkt_tag_i   = tag;
    tag_mem_pkt_state_i = (op == e_tag_set_tag) ? e_coh_s : e_coh_i;
    @(negedge clk_i);
    tag_mem_pkt_v_i = 1'b0;
    case (op)
      e_tag_set_clear: begin
        for (int w = 0; w < `ICACHE_ASSOC; w++) m_valid[set][w] = 1'b0;
      end
      e_tag_invalidate: m_valid[set][way] = 1'b0;
      default: begin
        m_tag[set][way]   = tag;
        m_valid[set][way] = 1'b1;
      end
    endcase
  endtask

  task automatic fill_way(input index_t set, input way_id_t way, input tag_t tag);
    cache_block_t blk;
    blk = random_block();
    send_tag(e_tag_set_tag, set, way, tag);
    wait_ready(2, "data_mem_pkt_ready_o");
    data_mem_pkt_v_i     = 1'b1;
    data_mem_pkt_index_i = set;
    data_mem_pkt_way_i   = way;
    data_mem_pkt_data_i  = blk;
    @(negedge clk_i);
    data_mem_pkt_v_i = 1'b0;
    m_block[set][way] = blk;
  endtask

  task automatic send_stat(input index_t set);
    wait_ready(3, "stat_mem_pkt_ready_o");
    stat_mem_pkt_v_i     = 1'b1;
    stat_mem_pkt_index_i = set;
    @(negedge clk_i);
    stat_mem_pkt_v_i = 1'b0;
    m_lru[set] = '0;
  endtask

  // accept, TL with the ptag, return at the TV falling edge
  task automatic issue_fetch(input logic [`PADDR_WIDTH-1:0] addr, input logic poison);
    wait_ready(0, "vaddr_ready_o");
    vaddr_i   = addr;
    vaddr_v_i = 1'b1;
    #1;
    // a fetch takes the array ports from the fill side
    check_flag("tag_mem_pkt_ready_o", tag_mem_pkt_ready_o, 1'b0);
    check_flag("data_mem_pkt_ready_o", data_mem_pkt_ready_o, 1'b0);
    @(negedge clk_i);
    vaddr_v_i = 1'b0;
    ptag_i    = addr[`PADDR_WIDTH-1 -: `PTAG_WIDTH];
    ptag_v_i  = 1'b1;
    poison_i  = poison;
    check_flag("data_v_o in TL", data_v_o, 1'b0);
    @(negedge clk_i);
    ptag_v_i = 1'b0;
    poison_i = 1'b0;
    // stat packets wait while TV is busy
    check_flag("stat_mem_pkt_ready_o", stat_mem_pkt_ready_o, poison);
  endtask

  task automatic fetch_hit(input logic [`PADDR_WIDTH-1:0] addr);
    index_t set;
    int way;
    logic [`DWORD_WIDTH-1:0] dw;
    set = addr[IDX_LSB +: `INDEX_WIDTH];
    way = model_way(addr);
    issue_fetch(addr, 1'b0);
    if (way < 0) begin
      errors++;
      $display("Error at %0t: address %h is not resident in the model", $time, addr);
    end else begin
      dw = m_block[set][way][addr[`BYTE_OFFSET_WIDTH +: `WORD_OFFSET_WIDTH]];
      check_flag("data_v_o", data_v_o, 1'b1);
      check_flag("cache_req_v_o", cache_req_v_o, 1'b0);
      check_instr("data_o", data_o, addr[2] ? dw[63:32] : dw[31:0]);
      model_touch(set, way_id_t'(way));
    end
  endtask

  task automatic fetch_miss(input logic [`PADDR_WIDTH-1:0] addr, input way_id_t exp_way);
    issue_fetch(addr, 1'b0);
    check_flag("data_v_o", data_v_o, 1'b0);
    check_flag("cache_req_v_o", cache_req_v_o, 1'b1);
    check_flag("miss_o", miss_o, 1'b1);
    check_addr("cache_req_addr_o", cache_req_addr_o, addr);
    @(negedge clk_i);
    check_flag("cache_req_metadata_v_o", cache_req_metadata_v_o, 1'b1);
    check_way("cache_req_repl_way_o", cache_req_repl_way_o, exp_way);
    // tracker holds until complete
    repeat (2) begin
      check_flag("miss_o", miss_o, 1'b1);
      check_flag("vaddr_ready_o", vaddr_ready_o, 1'b0);
      @(negedge clk_i);
    end
    cache_req_complete_i = 1'b1;
    @(negedge clk_i);
    cache_req_complete_i = 1'b0;
    check_flag("miss_o", miss_o, 1'b0);
    check_flag("vaddr_ready_o", vaddr_ready_o, 1'b1);
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic test_cold_miss();
    int e0;
    e0 = errors;
    for (int s = 0; s < `ICACHE_SETS; s++) begin
      send_tag(e_tag_set_clear, index_t'(s), '0, '0);
    end
    fetch_miss(make_addr(6'd5, fresh_tag(6'd5), 2'($urandom), 1'($urandom)), 2'd0);
    end_test("cold miss", e0);
  endtask

  task automatic test_block_fill();
    int e0;
    tag_t tag;
    e0 = errors;
    tag = fresh_tag(6'd12);
    fill_way(6'd12, model_victim(6'd12), tag);
    for (int i = 0; i < 8; i++) begin
      fetch_hit(make_addr(6'd12, tag, 2'(i >> 1), i[0]));
    end
    end_test("block fill", e0);
  endtask

  task automatic test_way_striping();
    int e0;
    e0 = errors;
    for (int w = 0; w < `ICACHE_ASSOC; w++) begin
      fill_way(6'd20, way_id_t'(w), {19'($urandom), 2'(w)});
    end
    for (int w = 0; w < `ICACHE_ASSOC; w++) begin
      for (int i = 0; i < 8; i++) begin
        fetch_hit(make_addr(6'd20, m_tag[20][w], 2'(i >> 1), i[0]));
      end
    end
    end_test("way striping", e0);
  endtask

  task automatic test_plru_victim();
    int e0;
    way_id_t w;
    e0 = errors;
    repeat (6) begin
      w = way_id_t'($urandom);
      fetch_hit(make_addr(6'd20, m_tag[20][w], 2'($urandom), 1'($urandom)));
    end
    // last touch on way 0 leaves the victim in ways 2-3
    fetch_hit(make_addr(6'd20, m_tag[20][0], 2'd0, 1'b0));
    fetch_miss(make_addr(6'd20, fresh_tag(6'd20), 2'd0, 1'b0), model_victim(6'd20));
    send_stat(6'd20);
    fetch_miss(make_addr(6'd20, fresh_tag(6'd20), 2'd1, 1'b0), 2'd0);
    end_test("pseudo-LRU victim", e0);
  endtask

  task automatic test_invalidate();
    int e0;
    tag_t old;
    e0 = errors;
    old = m_tag[20][2];
    send_tag(e_tag_invalidate, 6'd20, 2'd2, '0);
    fetch_miss(make_addr(6'd20, old, 2'd3, 1'b1), 2'd2);
    end_test("invalidate", e0);
  endtask

  task automatic test_poison_backpressure();
    int e0;
    logic [`PADDR_WIDTH-1:0] addr;
    e0 = errors;
    issue_fetch(make_addr(6'd12, m_tag[12][0], 2'd2, 1'b0), 1'b1);
    check_flag("data_v_o", data_v_o, 1'b0);
    check_flag("cache_req_v_o", cache_req_v_o, 1'b0);
    // cold miss whose TV cycle meets back-pressure
    addr = make_addr(6'd33, fresh_tag(6'd33), 2'd0, 1'b0);
    wait_ready(0, "vaddr_ready_o");
    vaddr_i   = addr;
    vaddr_v_i = 1'b1;
    @(negedge clk_i);
    ptag_i            = addr[`PADDR_WIDTH-1 -: `PTAG_WIDTH];
    ptag_v_i          = 1'b1;
    cache_req_ready_i = 1'b0;
    @(negedge clk_i);
    ptag_v_i = 1'b0;
    check_flag("miss_o", miss_o, 1'b1);
    check_flag("cache_req_v_o", cache_req_v_o, 1'b0);
    repeat (4) begin
      check_flag("vaddr_ready_o", vaddr_ready_o, 1'b0);
      @(negedge clk_i);
      check_flag("cache_req_metadata_v_o", cache_req_metadata_v_o, 1'b0);
      check_flag("miss_o", miss_o, 1'b0);
    end
    vaddr_v_i = 1'b0;
    cache_req_ready_i = 1'b1;
    // the dropped miss leaves no tracker behind
    @(negedge clk_i);
    check_flag("vaddr_ready_o", vaddr_ready_o, 1'b1);
    check_flag("miss_o", miss_o, 1'b0);
    end_test("poison and back-pressure", e0);
  endtask

  initial begin
    void'($urandom(32'h671414d3));
    errors = 0;
    checks = 0;
    tests_run = 0;
    for (int s = 0; s < `ICACHE_SETS; s++) m_lru[s] = '0;
    clk_i = 1'b0;
    reset_i = 1'b1;
    vaddr_i = '0;
    vaddr_v_i = 1'b0;
    ptag_i = '0;
    ptag_v_i = 1'b0;
    poison_i = 1'b0;
    cache_req_ready_i = 1'b1;
    cache_req_complete_i = 1'b0;
    tag_mem_pkt_v_i = 1'b0;
    tag_mem_pkt_op_i = e_tag_set_clear;
    tag_mem_pkt_index_i = '0;
    tag_mem_pkt_way_i = '0;
    tag_mem_pkt_tag_i = '0;
    tag_mem_pkt_state_i = e_coh_i;
    data_mem_pkt_v_i = 1'b0;
    data_mem_pkt_index_i = '0;
    data_mem_pkt_way_i = '0;
    data_mem_pkt_data_i = '0;
    stat_mem_pkt_v_i = 1'b0;
    stat_mem_pkt_index_i = '0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    test_cold_miss();
    test_block_fill();
    test_way_striping();
    test_plru_victim();
    test_invalidate();
    test_poison_backpressure();

    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: verification/icache_chk.sv
// Lookup pipeline checks
// Miss request and metadata ordering, and fetch blocking during a miss

`timescale 1ns/1ps

module icache_chk (
  input logic clk_i,
  input logic reset_i,
  input logic vaddr_ready_i,
  input logic data_v_i,
  input logic miss_i,
  input logic cache_req_v_i,
  input logic cache_req_metadata_v_i
);

  // metadata trails the request by exactly one cycle
  meta_after_req: assert property (@(posedge clk_i) disable iff (reset_i)
    cache_req_v_i |=> cache_req_metadata_v_i)
    else $error("metadata missing one cycle after a miss request");

  meta_only_after_req: assert property (@(posedge clk_i) disable iff (reset_i)
    cache_req_metadata_v_i |-> $past(cache_req_v_i))
    else $error("metadata without a miss request in the cycle before");

  hit_or_miss: assert property (@(posedge clk_i) disable iff (reset_i)
    !(data_v_i && cache_req_v_i))
    else $error("data valid and miss request in the same cycle");

  // no fetch accepted while a miss is open
  blocked_on_miss: assert property (@(posedge clk_i) disable iff (reset_i)
    miss_i |-> !vaddr_ready_i)
    else $error("fetch ready while a miss is held");

endmodule

bind icache_pipe icache_chk chk (
  .clk_i(clk_i),
  .reset_i(reset_i),
  .vaddr_ready_i(vaddr_ready_o),
  .data_v_i(data_v_o),
  .miss_i(miss_o),
  .cache_req_v_i(cache_req_v_o),
  .cache_req_metadata_v_i(cache_req_metadata_v_o)
);

// File: src/icache_top.sv
// Instruction cache top level
// 4-way VIPT cache: lookup pipeline, tag and data arrays and the
// pseudo-LRU state, fed by fill packets from the coherence side

`timescale 1ns/1ps

`include "icache_macros.svh"

module icache_top
  import icache_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              reset_i,

  input  logic [`VADDR_WIDTH-1:0]           vaddr_i,
  input  logic                              vaddr_v_i,
  output logic                              vaddr_ready_o,

  input  logic [`PTAG_WIDTH-1:0]            ptag_i,
  input  logic                              ptag_v_i,
  input  logic                              poison_i,

  output logic [`INSTR_WIDTH-1:0]           data_o,
  output logic                              data_v_o,
  output logic                              miss_o,

  output logic                              cache_req_v_o,
  output logic [`PADDR_WIDTH-1:0]           cache_req_addr_o,
  input  logic                              cache_req_ready_i,
  output logic                              cache_req_metadata_v_o,
  output way_id_t                           cache_req_repl_way_o,
  input  logic                              cache_req_complete_i,

  input  logic                              tag_mem_pkt_v_i,
  input  tag_op_e                           tag_mem_pkt_op_i,
  input  index_t                            tag_mem_pkt_index_i,
  input  way_id_t                           tag_mem_pkt_way_i,
  input  tag_t                              tag_mem_pkt_tag_i,
  input  coh_state_e                        tag_mem_pkt_state_i,
  output logic                              tag_mem_pkt_ready_o,

  input  logic                              data_mem_pkt_v_i,
  input  index_t                            data_mem_pkt_index_i,
  input  way_id_t                           data_mem_pkt_way_i,
  input  cache_block_t                      data_mem_pkt_data_i,
  output logic                              data_mem_pkt_ready_o,

  input  logic                              stat_mem_pkt_v_i,
  input  index_t                            stat_mem_pkt_index_i,
  output logic                              stat_mem_pkt_ready_o
);

  logic                              read_v;
  index_t                            read_index;
  logic [`WORD_OFFSET_WIDTH-1:0]     read_word;
  tag_t       [`ICACHE_ASSOC-1:0]    tag_rd;
  coh_state_e [`ICACHE_ASSOC-1:0]    state_rd;
  dword_u     [`ICACHE_ASSOC-1:0]    bank_data;
  logic                              tv_v;
  index_t                            tv_index;
  logic                              hit;
  way_id_t                           hit_way;
  logic [`ICACHE_ASSOC-1:0]          way_valid;
  way_id_t                           victim;

  icache_pipe pipe (
    .clk_i(clk_i), .reset_i(reset_i),
    .vaddr_i(vaddr_i), .vaddr_v_i(vaddr_v_i), .vaddr_ready_o(vaddr_ready_o),
    .ptag_i(ptag_i), .ptag_v_i(ptag_v_i), .poison_i(poison_i),
    .read_v_o(read_v), .read_index_o(read_index), .read_word_o(read_word),
    .tag_i(tag_rd), .state_i(state_rd), .bank_data_i(bank_data),
    .tv_v_o(tv_v), .tv_index_o(tv_index), .hit_o(hit), .hit_way_o(hit_way),
    .way_valid_o(way_valid),
    .data_o(data_o), .data_v_o(data_v_o), .miss_o(miss_o),
    .cache_req_ready_i(cache_req_ready_i), .cache_req_v_o(cache_req_v_o),
    .cache_req_addr_o(cache_req_addr_o), .victim_i(victim),
    .cache_req_metadata_v_o(cache_req_metadata_v_o),
    .cache_req_repl_way_o(cache_req_repl_way_o),
    .cache_req_complete_i(cache_req_complete_i)
  );

  icache_tag_array tag_array (
    .clk_i(clk_i), .reset_i(reset_i),
    .read_v_i(read_v), .read_index_i(read_index),
    .pkt_v_i(tag_mem_pkt_v_i), .pkt_op_i(tag_mem_pkt_op_i),
    .pkt_index_i(tag_mem_pkt_index_i), .pkt_way_i(tag_mem_pkt_way_i),
    .pkt_tag_i(tag_mem_pkt_tag_i), .pkt_state_i(tag_mem_pkt_state_i),
    .pkt_ready_o(tag_mem_pkt_ready_o),
    .tag_o(tag_rd), .state_o(state_rd)
  );

  icache_data_array data_array (
    .clk_i(clk_i), .reset_i(reset_i),
    .read_v_i(read_v), .read_index_i(read_index), .read_word_i(read_word),
    .pkt_v_i(data_mem_pkt_v_i), .pkt_index_i(data_mem_pkt_index_i),
    .pkt_way_i(data_mem_pkt_way_i), .pkt_block_i(data_mem_pkt_data_i),
    .pkt_ready_o(data_mem_pkt_ready_o),
    .bank_data_o(bank_data)
  );

  icache_lru lru (
    .clk_i(clk_i), .reset_i(reset_i),
    .tv_v_i(tv_v), .index_i(tv_index), .hit_i(hit), .hit_way_i(hit_way),
    .way_valid_i(way_valid),
    .pkt_v_i(stat_mem_pkt_v_i), .pkt_index_i(stat_mem_pkt_index_i),
    .pkt_ready_o(stat_mem_pkt_ready_o),
    .victim_o(victim)
  );

endmodule

// File: src/icache_pipe.sv
// Instruction cache lookup pipeline
// TL and TV stage registers, tag compare and instruction select, plus
// the miss request, its delayed metadata and the miss tracker

`timescale 1ns/1ps

`include "icache_macros.svh"

module icache_pipe
  import icache_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              reset_i,

  input  logic [`VADDR_WIDTH-1:0]           vaddr_i,
  input  logic                              vaddr_v_i,
  output logic                              vaddr_ready_o,

  input  logic [`PTAG_WIDTH-1:0]            ptag_i,
  input  logic                              ptag_v_i,
  input  logic                              poison_i,

  output logic                              read_v_o,
  output index_t                            read_index_o,
  output logic [`WORD_OFFSET_WIDTH-1:0]     read_word_o,

  input  tag_t       [`ICACHE_ASSOC-1:0]    tag_i,
  input  coh_state_e [`ICACHE_ASSOC-1:0]    state_i,
  input  dword_u     [`ICACHE_ASSOC-1:0]    bank_data_i,

  output logic                              tv_v_o,
  output index_t                            tv_index_o,
  output logic                              hit_o,
  output way_id_t                           hit_way_o,
  output logic [`ICACHE_ASSOC-1:0]          way_valid_o,

  output logic [`INSTR_WIDTH-1:0]           data_o,
  output logic                              data_v_o,
  output logic                              miss_o,

  input  logic                              cache_req_ready_i,
  output logic                              cache_req_v_o,
  output logic [`PADDR_WIDTH-1:0]           cache_req_addr_o,

  input  way_id_t                           victim_i,
  output logic                              cache_req_metadata_v_o,
  output way_id_t                           cache_req_repl_way_o,

  input  logic                              cache_req_complete_i
);

  localparam int BLOCK_OFFSET_W = `BYTE_OFFSET_WIDTH + `WORD_OFFSET_WIDTH;

  logic                                tl_we;
  logic                                tv_we;
  logic                                v_tl_r;
  logic [`PAGE_OFFSET_WIDTH-1:0]       page_offset_tl_r;

  logic                                v_tv_r;
  logic [`PADDR_WIDTH-1:0]             addr_tv_r;
  tag_t       [`ICACHE_ASSOC-1:0]      tag_tv_r;
  coh_state_e [`ICACHE_ASSOC-1:0]      state_tv_r;
  dword_u     [`ICACHE_ASSOC-1:0]      data_tv_r;

  tag_t                                addr_tag_tv;
  logic [`WORD_OFFSET_WIDTH-1:0]       word_tv;
  logic [`ICACHE_ASSOC-1:0]            hit_v;
  logic                                hit_any;
  way_id_t                             hit_way;
  dword_u                              picked;
  logic                                miss_tv;
  logic                                miss_tracker_r;

  // fetch accept and the array read in the same cycle
  assign vaddr_ready_o = cache_req_ready_i & ~(cache_req_v_o | miss_tracker_r);
  assign tl_we         = vaddr_v_i & vaddr_ready_o;
  assign read_v_o      = tl_we;
  assign read_index_o  = vaddr_i[BLOCK_OFFSET_W +: `INDEX_WIDTH];
  assign read_word_o   = vaddr_i[`BYTE_OFFSET_WIDTH +: `WORD_OFFSET_WIDTH];

  assign tv_we = v_tl_r & ptag_v_i & ~poison_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_tl_r <= 1'b0;
      v_tv_r <= 1'b0;
    end else begin
      v_tl_r <= tl_we;
      v_tv_r <= tv_we;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tl_we) begin
      page_offset_tl_r <= vaddr_i[`PAGE_OFFSET_WIDTH-1:0];
    end
    if (tv_we) begin
      addr_tv_r  <= {ptag_i, page_offset_tl_r};
      tag_tv_r   <= tag_i;
      state_tv_r <= state_i;
      data_tv_r  <= bank_data_i;
    end
  end

  assign addr_tag_tv = addr_tv_r[BLOCK_OFFSET_W + `INDEX_WIDTH +: `TAG_WIDTH];
  assign tv_index_o  = addr_tv_r[BLOCK_OFFSET_W +: `INDEX_WIDTH];
  assign word_tv     = addr_tv_r[`BYTE_OFFSET_WIDTH +: `WORD_OFFSET_WIDTH];

  for (genvar i = 0; i < `ICACHE_ASSOC; i++) begin : g_cmp
    assign way_valid_o[i] = (state_tv_r[i] != e_coh_i);
    assign hit_v[i]       = way_valid_o[i] && (tag_tv_r[i] == addr_tag_tv);
  end

  // lowest hitting way
  always_comb begin
    hit_way = '0;
    for (int i = `ICACHE_ASSOC-1; i >= 0; i--) begin
      if (hit_v[i]) hit_way = way_id_t'(i);
    end
  end

  assign hit_any   = |hit_v;
  assign tv_v_o    = v_tv_r;
  assign hit_o     = hit_any;
  assign hit_way_o = hit_way;

  // undo the bank striping, then take the instruction half
  assign picked   = data_tv_r[hit_way ^ word_tv];
  assign data_o   = picked.instr[addr_tv_r[`BYTE_OFFSET_WIDTH-1]];
  assign data_v_o = v_tv_r & hit_any;

  // a second miss behind a pending one is dropped and refetched
  assign miss_tv          = v_tv_r & ~hit_any;
  assign cache_req_v_o    = miss_tv & cache_req_ready_i & ~miss_tracker_r;
  assign cache_req_addr_o = addr_tv_r;
  assign miss_o           = miss_tv | miss_tracker_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cache_req_metadata_v_o <= 1'b0;
      miss_tracker_r         <= 1'b0;
    end else begin
      cache_req_metadata_v_o <= cache_req_v_o;
      if (cache_req_v_o) begin
        miss_tracker_r <= 1'b1;
      end else if (cache_req_complete_i) begin
        miss_tracker_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cache_req_v_o) begin
      cache_req_repl_way_o <= victim_i;
    end
  end

endmodule

// File: src/icache_lru.sv
// Instruction cache replacement state
// Tree pseudo-LRU bits per set, updated on TV hits and cleared by
// stat packets; picks the victim for a miss

`timescale 1ns/1ps

`include "icache_macros.svh"

module icache_lru
  import icache_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       reset_i,

  input  logic                       tv_v_i,
  input  index_t                     index_i,
  input  logic                       hit_i,
  input  way_id_t                    hit_way_i,
  input  logic [`ICACHE_ASSOC-1:0]   way_valid_i,

  input  logic                       pkt_v_i,
  input  index_t                     pkt_index_i,
  output logic                       pkt_ready_o,

  output way_id_t                    victim_o
);

  lru_t                     lru_q [`ICACHE_SETS];
  lru_t                     lru_rd;
  logic [`ICACHE_ASSOC-1:0] invalid;
  way_id_t                  invalid_way;
  way_id_t                  lru_way;

  assign pkt_ready_o = ~tv_v_i;
  assign lru_rd      = lru_q[index_i];
  assign invalid     = ~way_valid_i;

  // lowest invalid way
  always_comb begin
    invalid_way = '0;
    for (int i = `ICACHE_ASSOC-1; i >= 0; i--) begin
      if (invalid[i]) invalid_way = way_id_t'(i);
    end
  end

  // walk down from the root where 0 means left
  assign lru_way  = lru_rd[0] ? {1'b1, lru_rd[2]} : {1'b0, lru_rd[1]};
  assign victim_o = (|invalid) ? invalid_way : lru_way;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < `ICACHE_SETS; s++) begin
        lru_q[s] <= '0;
      end
    end else if (tv_v_i && hit_i) begin
      // point away from the hit way at both levels
      lru_q[index_i][0] <= ~hit_way_i[1];
      if (hit_way_i[1]) begin
        lru_q[index_i][2] <= ~hit_way_i[0];
      end else begin
        lru_q[index_i][1] <= ~hit_way_i[0];
      end
    end else if (pkt_v_i && pkt_ready_o) begin
      lru_q[pkt_index_i] <= '0;
    end
  end

endmodule

// File: src/icache_data_array.sv
// Instruction cache data array
// Four dword banks with the ways striped across them, so one fill
// writes a whole block in a single cycle and one read returns a given
// word of every way

`timescale 1ns/1ps

`include "icache_macros.svh"

module icache_data_array
  import icache_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              reset_i,

  input  logic                              read_v_i,
  input  index_t                            read_index_i,
  input  logic [`WORD_OFFSET_WIDTH-1:0]     read_word_i,

  input  logic                              pkt_v_i,
  input  index_t                            pkt_index_i,
  input  way_id_t                           pkt_way_i,
  input  cache_block_t                      pkt_block_i,
  output logic                              pkt_ready_o,

  output dword_u [`ICACHE_ASSOC-1:0]        bank_data_o
);

  localparam int ADDR_W = `INDEX_WIDTH + `WORD_OFFSET_WIDTH;
  localparam int DEPTH  = `ICACHE_SETS * `ICACHE_ASSOC;

  logic wr_en;

  // fetch read wins the banks
  assign pkt_ready_o = ~read_v_i;
  assign wr_en       = pkt_v_i & ~read_v_i;

  for (genvar b = 0; b < `ICACHE_ASSOC; b++) begin : g_bank
    logic [`DWORD_WIDTH-1:0]       mem [DEPTH];
    logic [`DWORD_WIDTH-1:0]       rd_q;
    logic [`WORD_OFFSET_WIDTH-1:0] fill_slot;
    logic [ADDR_W-1:0]             addr;

    // bank b, slot s holds dword s of way (s ^ b)
    assign fill_slot = pkt_way_i ^ `WORD_OFFSET_WIDTH'(b);
    assign addr      = read_v_i ? {read_index_i, read_word_i} : {pkt_index_i, fill_slot};

    always_ff @(posedge clk_i) begin
      if (!reset_i) begin
        if (read_v_i) begin
          rd_q <= mem[addr];
        end else if (wr_en) begin
          mem[addr] <= pkt_block_i[fill_slot];
        end
      end
    end

    assign bank_data_o[b].raw = rd_q;
  end

endmodule

// File: src/icache_tag_array.sv
// Instruction cache tag array
// Single-port tag and state store with one-cycle reads; tag packets
// are decoded into a per-way write mask

`timescale 1ns/1ps

`include "icache_macros.svh"

module icache_tag_array
  import icache_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              reset_i,

  input  logic                              read_v_i,
  input  index_t                            read_index_i,

  input  logic                              pkt_v_i,
  input  tag_op_e                           pkt_op_i,
  input  index_t                            pkt_index_i,
  input  way_id_t                           pkt_way_i,
  input  tag_t                              pkt_tag_i,
  input  coh_state_e                        pkt_state_i,
  output logic                              pkt_ready_o,

  output tag_t       [`ICACHE_ASSOC-1:0]    tag_o,
  output coh_state_e [`ICACHE_ASSOC-1:0]    state_o
);

  localparam int COH_W   = $bits(coh_state_e);
  localparam int ENTRY_W = `TAG_WIDTH + COH_W;

  // entry layout is {state, tag}
  logic [`ICACHE_ASSOC-1:0][ENTRY_W-1:0] mem [`ICACHE_SETS];
  logic [`ICACHE_ASSOC-1:0][ENTRY_W-1:0] rd_q;
  logic [`ICACHE_ASSOC-1:0][ENTRY_W-1:0] wr_data;
  logic [`ICACHE_ASSOC-1:0][ENTRY_W-1:0] wr_mask;
  logic [`ICACHE_ASSOC-1:0]              way_onehot;
  index_t                                addr;

  // fetch read wins the port
  assign pkt_ready_o = ~read_v_i;
  assign addr        = read_v_i ? read_index_i : pkt_index_i;
  assign way_onehot  = {{(`ICACHE_ASSOC-1){1'b0}}, 1'b1} << pkt_way_i;

  always_comb begin
    for (int i = 0; i < `ICACHE_ASSOC; i++) begin
      case (pkt_op_i)
        e_tag_set_clear: begin
          wr_data[i] = '0;
          wr_mask[i] = '1;
        end
        e_tag_invalidate: begin
          wr_data[i] = '0;
          wr_mask[i] = {{COH_W{way_onehot[i]}}, {`TAG_WIDTH{1'b0}}};
        end
        e_tag_set_tag: begin
          wr_data[i] = {pkt_state_i, pkt_tag_i};
          wr_mask[i] = {ENTRY_W{way_onehot[i]}};
        end
        default: begin
          wr_data[i] = '0;
          wr_mask[i] = '0;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      if (read_v_i) begin
        rd_q <= mem[addr];
      end else if (pkt_v_i) begin
        mem[addr] <= (mem[addr] & ~wr_mask) | (wr_data & wr_mask);
      end
    end
  end

  for (genvar i = 0; i < `ICACHE_ASSOC; i++) begin : g_way
    assign tag_o[i]   = rd_q[i][`TAG_WIDTH-1:0];
    assign state_o[i] = coh_state_e'(rd_q[i][`TAG_WIDTH +: COH_W]);
  end

endmodule

// File: src/icache_pkg.sv
// Instruction cache package
// Coherence state, tag packet opcodes and the storage types of the cache

`include "icache_macros.svh"

package icache_pkg;

  typedef enum logic [1:0] {
    e_coh_i = 2'b00,
    e_coh_s = 2'b01
  } coh_state_e;

  typedef enum logic [1:0] {
    e_tag_set_clear  = 2'b00,
    e_tag_invalidate = 2'b01,
    e_tag_set_tag    = 2'b10
  } tag_op_e;

  typedef logic [`WAY_WIDTH-1:0] way_id_t;
  typedef logic [`INDEX_WIDTH-1:0] index_t;
  typedef logic [`TAG_WIDTH-1:0] tag_t;

  // one bank word, seen whole or as two instructions
  typedef union packed {
    logic [`DWORD_WIDTH-1:0] raw;
    logic [1:0][`INSTR_WIDTH-1:0] instr;
  } dword_u;

  // a full cache block, dword 0 in the low bits
  typedef logic [`ICACHE_ASSOC-1:0][`DWORD_WIDTH-1:0] cache_block_t;

  // bit 0 root, bit 1 ways 0-1, bit 2 ways 2-3
  typedef logic [2:0] lru_t;

endpackage

// File: include/icache_macros.svh
// Instruction cache geometry
// Set, way and address field widths shared by the cache RTL and testbench

`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// organization
`define ICACHE_SETS 64
`define ICACHE_ASSOC 4

// data widths
`define DWORD_WIDTH 64
`define INSTR_WIDTH 32

// address widths
`define PADDR_WIDTH 32
`define VADDR_WIDTH 32
`define PAGE_OFFSET_WIDTH 12

// physical address fields, low to high
`define BYTE_OFFSET_WIDTH 3
`define WORD_OFFSET_WIDTH 2
`define INDEX_WIDTH 6
`define TAG_WIDTH 21
`define PTAG_WIDTH 20
`define WAY_WIDTH 2

`endif
